// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps
TOP       ?= d_mem_wrap_tb
FILELIST  ?= lotr_dmem.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir obj_dir -f $(FILELIST)

# Status comes from the search for the pass line in the log
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: logic/cr_regs.sv
`timescale 1ns/1ps

module cr_regs #(
    // Strap value returned at CR_CORE_ID
    parameter logic [31:0] CORE_ID = 32'h0000_0000
) (
    input  logic                 clock,
    input  logic                 rst,
    input  dmem_pkg::t_mem_req   req,
    output dmem_pkg::t_cr        cr,
    output logic [31:0]          q
);
    import dmem_pkg::*;

    // Scratch word, full 32-bit read/write
    logic [31:0]     scratch;

    // Offset inside the control region
    logic [MSB_CR:0] offset;

    // Qualified strobes
    logic            wr_hit;
    logic            rd_hit;

    // Read mux before the output flop
    logic [31:0]     rd_data;

    assign offset = req.addr[MSB_CR:0];
    assign wr_hit = req.wren && (req.region == REGION_CR);
    assign rd_hit = req.rden && (req.region == REGION_CR);

    // ========================================
    // Register write
    // ========================================

    always_ff @(posedge clock) begin
        if (rst) begin
            // Core held idle out of reset
            cr.en_pc  <= 1'b0;
            cr.rst_pc <= 1'b0;
            scratch   <= '0;
        end else if (wr_hit) begin
            // Always a full-word write, byteena ignored here
            case (offset)
                CR_EN_PC:   cr.en_pc  <= req.data[0];
                CR_RST_PC:  cr.rst_pc <= req.data[0];
                CR_SCRATCH: scratch   <= req.data;
                // Identity registers are read only
                default: ;
            endcase
        end
    end

    // ========================================
    // Register read
    // ========================================

    always_comb begin
        case (offset)
            CR_EN_PC:     rd_data = {31'b0, cr.en_pc};
            CR_RST_PC:    rd_data = {31'b0, cr.rst_pc};
            CR_CORE_ID:   rd_data = CORE_ID;
            // Thread of this very request
            CR_THREAD_ID: rd_data = {30'b0, req.thread};
            CR_SCRATCH:   rd_data = scratch;
            default:      rd_data = 32'b0;
        endcase
    end

    // Sampled only on a control read, held otherwise
    always_ff @(posedge clock) begin
        if (rd_hit) begin
            q <= rd_data;
        end
    end

endmodule

// File: logic/d_mem.sv
`timescale 1ns/1ps

module d_mem #(
    // Word address width, 2^AW words
    parameter int D_MEM_AW = 10
) (
    input  logic                 clock,
    input  dmem_pkg::t_mem_req   req,
    output logic [31:0]          q
);
    import dmem_pkg::*;

    // Behavioural storage, no reset on contents
    logic [31:0] mem [2**D_MEM_AW];

    // Word index from the byte address
    logic [D_MEM_AW-1:0] word_idx;

    // Strobes qualified by the region tag
    logic                wr_hit;
    logic                rd_hit;

    assign word_idx = req.addr[D_MEM_AW+1:2];
    assign wr_hit   = req.wren && (req.region == REGION_DMEM);
    assign rd_hit   = req.rden && (req.region == REGION_DMEM);

    // ========================================
    // Byte-enabled write
    // ========================================

    always_ff @(posedge clock) begin
        if (wr_hit) begin
            // Only enabled lanes change
            for (int b = 0; b < 4; b++) begin
                if (req.byteena[b]) begin
                    mem[word_idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // ========================================
    // Registered read
    // ========================================

    // q holds until the next RAM read
    always_ff @(posedge clock) begin
        if (rd_hit) begin
            q <= mem[word_idx];
        end
    end

endmodule

// File: logic/d_mem_wrap.sv
`timescale 1ns/1ps

module d_mem_wrap #(
    parameter int          D_MEM_AW = 10,
    parameter logic [31:0] CORE_ID  = 32'h0000_0000
) (
    input  logic                 clock,
    input  logic                 rst,
    // Core port
    input  logic [31:0]          address,
    input  logic [3:0]           byteena,
    input  logic [31:0]          data,
    input  logic                 rden,
    input  logic                 wren,
    input  logic [1:0]           thread,
    output logic [31:0]          q,
    // Level controls to the core
    output dmem_pkg::t_cr        cr
);
    import dmem_pkg::*;

    // Decoded request shared by both regions
    t_mem_req    req;

    // Per-region read data
    logic [31:0] dmem_q;
    logic [31:0] cr_q;

    // ========================================
    // Datapath
    // ========================================

    dmem_decode dmem_decode (
        .address (address),
        .byteena (byteena),
        .data    (data),
        .rden    (rden),
        .wren    (wren),
        .thread  (thread),
        .req     (req)
    );

    d_mem #(.D_MEM_AW(D_MEM_AW)) d_mem (
        .clock (clock),
        .req   (req),
        .q     (dmem_q)
    );

    cr_regs #(.CORE_ID(CORE_ID)) cr_regs (
        .clock (clock),
        .rst   (rst),
        .req   (req),
        .cr    (cr),
        .q     (cr_q)
    );

    // Picks the word for the read issued last edge
    read_return read_return (
        .clock  (clock),
        .rst    (rst),
        .rden   (req.rden),
        .region (req.region),
        .dmem_q (dmem_q),
        .cr_q   (cr_q),
        .q      (q)
    );

endmodule

// File: logic/dmem_decode.sv
`timescale 1ns/1ps

module dmem_decode (
    input  logic [31:0]          address,
    input  logic [3:0]           byteena,
    input  logic [31:0]          data,
    input  logic                 rden,
    input  logic                 wren,
    input  logic [1:0]           thread,
    output dmem_pkg::t_mem_req   req
);
    import dmem_pkg::*;

    // Region field of the incoming address
    logic [MSB_REGION-LSB_REGION:0] region_field;

    assign region_field = address[MSB_REGION:LSB_REGION];

    // ========================================
    // Request bundle
    // ========================================

    always_comb begin
        // Pass the strobes through untouched
        req.addr    = address;
        req.byteena = byteena;
        req.data    = data;
        req.rden    = rden;
        req.wren    = wren;
        req.thread  = thread;

        // Tag the target once so later blocks skip the compare
        if (region_field == D_MEM_REGION) begin
            req.region = REGION_DMEM;
        end else if (region_field == CR_REGION) begin
            req.region = REGION_CR;
        end else begin
            // Unmapped space, nobody acts on it
            req.region = REGION_NONE;
        end
    end

endmodule

// File: logic/dmem_pkg.sv
package dmem_pkg;

    // ========================================
    // Address map
    // ========================================

    // Region field inside the byte address
    localparam int LSB_REGION = 16;
    localparam int MSB_REGION = 23;

    // Region codes
    localparam logic [7:0] D_MEM_REGION = 8'h01;
    localparam logic [7:0] CR_REGION    = 8'h02;

    // Offset field of the control region, bits 7:0
    localparam int MSB_CR = 7;

    // Control register byte offsets
    localparam logic [MSB_CR:0] CR_EN_PC     = 8'h00;
    localparam logic [MSB_CR:0] CR_RST_PC    = 8'h04;
    localparam logic [MSB_CR:0] CR_CORE_ID   = 8'h08;
    localparam logic [MSB_CR:0] CR_THREAD_ID = 8'h0C;
    localparam logic [MSB_CR:0] CR_SCRATCH   = 8'h10;

    // ========================================
    // Types
    // ========================================

    // Decoded target of a request
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_DMEM = 2'd1,
        REGION_CR   = 2'd2
    } t_region;

    // One core request, tagged once at the input side
    typedef struct packed {
        // Byte address from the core
        logic [31:0] addr;
        // Per-byte write enables
        logic [3:0]  byteena;
        // Write payload
        logic [31:0] data;
        logic        rden;
        logic        wren;
        // Requesting hardware thread
        logic [1:0]  thread;
        // Result of the region compare
        t_region     region;
    } t_mem_req;

    // Level controls driven back to the core
    typedef struct packed {
        // Fetch enable
        logic en_pc;
        // Hold PC in reset
        logic rst_pc;
    } t_cr;

endpackage

// File: logic/read_return.sv
`timescale 1ns/1ps

module read_return (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 rden,
    input  dmem_pkg::t_region    region,
    input  logic [31:0]          dmem_q,
    input  logic [31:0]          cr_q,
    output logic [31:0]          q
);
    import dmem_pkg::*;

    // Region of the read now in flight
    t_region sel_region;

    // ========================================
    // Region select flop
    // ========================================

    always_ff @(posedge clock) begin
        if (rst) begin
            // q reads zero after reset
            sel_region <= REGION_NONE;
        end else if (rden) begin
            // Captured at the same edge as the source data
            sel_region <= region;
        end
    end

    // ========================================
    // Output mux
    // ========================================

    always_comb begin
        case (sel_region)
            REGION_DMEM: q = dmem_q;
            REGION_CR:   q = cr_q;
            // Unmapped reads return zero
            default:     q = 32'b0;
        endcase
    end

endmodule

// File: lotr_dmem.f
logic/dmem_pkg.sv
logic/dmem_decode.sv
logic/d_mem.sv
logic/cr_regs.sv
logic/read_return.sv
logic/d_mem_wrap.sv
tests/d_mem_wrap_tb.sv

// File: tests/d_mem_trace.txt
# test op thread address byteena data expected (hex except test and thread)
# op W writes, R reads and expects q, C checks cr as {en_pc, rst_pc}
1 C 0 00000000 0 00000000 00000000
1 R 0 00020000 0 00000000 00000000
1 R 0 00020004 0 00000000 00000000
1 R 0 00020010 0 00000000 00000000
2 W 0 00010040 f 11223344 00000000
2 R 0 00010040 f 00000000 11223344
2 W 1 00010040 5 aabbccdd 00000000
2 R 1 00010040 0 00000000 11bb33dd
2 W 2 00010ffc f 5a5aa5a5 00000000
2 W 2 00010ffc a 00ff00ff 00000000
2 R 2 00010ffc 0 00000000 005a00a5
3 W 0 00020000 f ffffffff 00000000
3 C 0 00000000 0 00000000 00000002
3 R 0 00020000 0 00000000 00000001
3 R 0 00020004 0 00000000 00000000
3 W 0 00020004 f 00000001 00000000
3 C 0 00000000 0 00000000 00000003
3 R 0 00020004 0 00000000 00000001
3 W 0 00020000 f fffffffe 00000000
3 C 0 00000000 0 00000000 00000001
3 R 0 00020000 0 00000000 00000000
4 R 0 00020008 0 00000000 00000005
4 R 3 00020008 0 00000000 00000005
4 R 0 0002000c 0 00000000 00000000
4 R 1 0002000c 0 00000000 00000001
4 R 2 0002000c 0 00000000 00000002
4 R 3 0002000c 0 00000000 00000003
5 W 2 00020010 f deadbeef 00000000
5 R 2 00020010 0 00000000 deadbeef
5 W 0 00020010 1 12345678 00000000
5 R 0 00020010 0 00000000 12345678
5 R 0 00020014 0 00000000 00000000
5 W 0 00010080 f cafef00d 00000000
5 W 0 00030080 f 0badc0de 00000000
5 R 0 00030080 0 00000000 00000000
5 R 0 00010080 0 00000000 cafef00d
6 W 0 00010100 f a5a50001 00000000
6 W 0 00010104 f a5a50002 00000000
6 R 1 00010100 0 00000000 a5a50001
6 R 1 00020010 0 00000000 12345678
6 R 2 00010104 0 00000000 a5a50002
6 R 2 0002000c 0 00000000 00000002
6 R 0 00030000 0 00000000 00000000
6 R 3 00010100 0 00000000 a5a50001

// File: tests/d_mem_wrap_tb.sv
`timescale 1ns/1ps

module d_mem_wrap_tb;
    import dmem_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 10;
    localparam string TRACE_FILE   = "tests/d_mem_trace.txt";

    // One parsed trace line
    typedef struct packed {
        logic [15:0] test;
        // W, R or C as an ASCII code
        logic [7:0]  op;
        logic [1:0]  thread;
        logic [31:0] addr;
        logic [3:0]  byteena;
        logic [31:0] data;
        // q for R and {en_pc, rst_pc} for C
        logic [31:0] expected;
    } t_trace_op;

    // DUT ports
    logic        clock;
    logic        rst;
    logic [31:0] address;
    logic [3:0]  byteena;
    logic [31:0] data;
    logic        rden;
    logic        wren;
    logic [1:0]  thread;
    logic [31:0] q;
    t_cr         cr;

    // Trace contents and bookkeeping
    t_trace_op   ops[$];
    int          trace_lines;
    int          load_errors;
    bit          trace_loaded;

    // Read taken at the last edge and checked one edge later
    bit          read_pending;
    t_trace_op   pending_op;

    // Per-test and overall counts
    int          test_checks;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    d_mem_wrap #(
        .D_MEM_AW (10),
        .CORE_ID  (32'h0000_0005)
    ) dut0 (
        .clock   (clock),
        .rst     (rst),
        .address (address),
        .byteena (byteena),
        .data    (data),
        .rden    (rden),
        .wren    (wren),
        .thread  (thread),
        .q       (q),
        .cr      (cr)
    );

    // ========================================
    // Clock and watchdog
    // ========================================

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Budget of three clocks per trace line plus slack for reset
    initial begin
        wait (trace_loaded);
        #((trace_lines + 20) * 3 * CLK_PERIOD);
        $display("Timeout: the trace did not complete in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        test_checks++;
        if (got !== expected) begin
            test_errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
        end
    endtask

    // Reads characters up to the newline and flags end of file
    task automatic read_line(input int fd, output string line, output bit at_eof);
        int c;
        line   = "";
        at_eof = 1'b0;
        forever begin
            c = $fgetc(fd);
            if (c == -1) begin
                at_eof = 1'b1;
                break;
            end
            if (c == 10) begin
                break;
            end
            line = $sformatf("%s%c", line, c);
        end
    endtask

    // First non-blank character or zero on an empty line
    function automatic byte first_char(input string line);
        for (int i = 0; i < line.len(); i++) begin
            if (line[i] != " " && line[i] != 8'h09 && line[i] != 8'h0d) begin
                return line[i];
            end
        end
        return 8'd0;
    endfunction

    task automatic load_trace(output bit ok);
        int          fd;
        int          code;
        int          f_test;
        int          f_thread;
        bit          at_eof;
        byte         lead;
        string       line;
        logic [7:0]  f_op;
        logic [31:0] f_addr;
        logic [31:0] f_be;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        t_trace_op   entry;
        ok     = 1'b0;
        at_eof = 1'b0;
        fd     = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Trace file %s could not be opened", TRACE_FILE);
            return;
        end
        while (!at_eof) begin
            read_line(fd, line, at_eof);
            trace_lines++;
            lead = first_char(line);
            // Blank lines and comments
            if (lead == 8'd0 || lead == "#") begin
                continue;
            end
            code = $sscanf(line, "%d %c %d %h %h %h %h",
                           f_test, f_op, f_thread, f_addr, f_be, f_data, f_exp);
            if (code != 7 || !(f_op inside {"W", "R", "C"}) || f_thread > 3 || f_be > 15) begin
                $display("Trace line %0d is malformed and was skipped: %s", trace_lines, line);
                load_errors++;
                continue;
            end
            entry.test     = f_test[15:0];
            entry.op       = f_op;
            entry.thread   = f_thread[1:0];
            entry.addr     = f_addr;
            entry.byteena  = f_be[3:0];
            entry.data     = f_data;
            entry.expected = f_exp;
            ops.push_back(entry);
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            $display("Trace file %s holds no operations", TRACE_FILE);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic drive_idle();
        address = 32'h0;
        byteena = 4'h0;
        data    = 32'h0;
        rden    = 1'b0;
        wren    = 1'b0;
        thread  = 2'd0;
    endtask

    task automatic drive_op(input t_trace_op op);
        address = op.addr;
        byteena = op.byteena;
        data    = op.data;
        rden    = (op.op == "R");
        wren    = (op.op == "W");
        thread  = op.thread;
    endtask

    // q for a read taken at the previous edge
    task automatic check_pending_read();
        if (read_pending) begin
            check_value(q, pending_op.expected,
                        $sformatf("test %0d read of %h", pending_op.test, pending_op.addr));
            read_pending = 1'b0;
        end
    endtask

    task automatic finish_test(input logic [15:0] test_no);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d checks", test_no, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d checks wrong",
                     test_no, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // ========================================
    // Trace replay
    // ========================================

    task automatic run_trace();
        logic [15:0] cur_test;
        cur_test = ops[0].test;
        foreach (ops[i]) begin
            @(posedge clock);
            #1;
            // Results of the last edge before the next request
            check_pending_read();
            if (ops[i].test != cur_test) begin
                finish_test(cur_test);
                cur_test = ops[i].test;
            end
            if (ops[i].op == "C") begin
                drive_idle();
                check_value({30'b0, cr}, ops[i].expected,
                            $sformatf("test %0d cr bits", ops[i].test));
            end else begin
                drive_op(ops[i]);
            end
            read_pending = (ops[i].op == "R");
            pending_op   = ops[i];
        end
        // Drain the last read
        @(posedge clock);
        #1;
        check_pending_read();
        drive_idle();
        finish_test(cur_test);
    endtask

    initial begin
        bit loaded_ok;
        rst          = 1'b1;
        trace_loaded = 1'b0;
        read_pending = 1'b0;
        drive_idle();
        load_trace(loaded_ok);
        if (!loaded_ok) begin
            $display("SOME TESTS FAILED");
        end else begin
            trace_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clock);
            #1;
            rst = 1'b0;
            // Read return select leaves reset as unmapped
            check_value(q, 32'h0, "q after reset");
            run_trace();
            $display("tests passed: %0d, tests failed: %0d, bad trace lines: %0d",
                     tests_passed, tests_failed, load_errors);
            if (tests_failed == 0 && load_errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
        end
        $finish;
    end

endmodule
